// File: Bender.yml
package:
  name: riscv_core

sources:
  - files:
      - verilog/riscv_isa_pkg.sv
      - verilog/riscv_ctrl_pkg.sv
      - verilog/ctrl_if.sv
      - verilog/alu.sv
      - verilog/controller.sv
      - verilog/datapath.sv
      - verilog/riscv_core.sv
  - target: test
    files:
      - tb/riscv_core_tb.sv

// File: riscv_core.f
verilog/riscv_isa_pkg.sv
verilog/riscv_ctrl_pkg.sv
verilog/ctrl_if.sv
verilog/alu.sv
verilog/controller.sv
verilog/datapath.sv
verilog/riscv_core.sv
tb/riscv_core_tb.sv

// File: tb/riscv_core_tb.sv
`timescale 1ns/1ps

module riscv_core_tb;
    localparam logic [31:0] reset_addr = 32'h0000_0100;
    localparam logic [31:0] done_addr  = 32'h0000_03fc;  // store here ends a program
    localparam int          timeout    = 400;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] trace [$];  // fetch addresses of the last run
    logic [31:0] lcg_state;
    int          wr_idx;
    int          errors;
    int          tests;

    riscv_core #(
        .reset_addr (reset_addr)
    ) riscv_core_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // both memories answer within the cycle
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_word(logic [2:0] f3, logic alt, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, riscv_isa_pkg::op_reg};
    endfunction

    function automatic logic [31:0] i_word(riscv_isa_pkg::opcode_t op, logic [2:0] f3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_isa_pkg::op_store};
    endfunction

    function automatic logic [31:0] b_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_isa_pkg::op_branch};
    endfunction

    function automatic logic [31:0] j_word(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, riscv_isa_pkg::op_jal};
    endfunction

    // RV32I arithmetic, alt picks sub / sra
    function automatic logic [31:0] model_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit model_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report(string name, int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic clear_memories();
        for (int k = 0; k < 256; k++) begin
            imem[k] = i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd0, 5'd0, 12'(k));  // nop
            dmem[k] = 32'hdead_0000 | 32'(k);
        end
        wr_idx = reset_addr[9:2];
    endtask

    task automatic put(logic [31:0] word);
        imem[wr_idx] = word;
        wr_idx++;
    endtask

    task automatic hold_reset();
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
    endtask

    task automatic run_program();
        bit done;
        done = 1'b0;
        trace.delete();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < timeout && !done; n++) begin
            @(negedge clk);
            trace.push_back(imem_addr);
            done = dmem_we && (dmem_addr == done_addr);
        end
        if (!done) begin
            $display("program did not reach its final store within %0d cycles", timeout);
            errors++;
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        hold_reset();
        clear_memories();
        put(s_word(5'd0, 5'd0, 12'h200));  // only fetched while reset is high
        wr_idx = wr_idx + 1;  // two nops, then a store
        put(s_word(5'd0, 5'd0, done_addr[11:0]));
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            if (k == 2) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            compare("imem_addr", imem_addr, reset_addr);
            compare("dmem_we", {31'd0, dmem_we}, 32'd0);
            if (k == 1) begin
                // a nop takes its place before reset falls
                imem[reset_addr[9:2]] = i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd0, 5'd0,
                                               12'd0);
            end
        end
        @(negedge clk);
        compare("imem_addr", imem_addr, reset_addr + 32'd4);
        @(negedge clk);
        compare("imem_addr", imem_addr, reset_addr + 32'd8);
        compare("dmem_we", {31'd0, dmem_we}, 32'd1);
        report("reset", e0);
    endtask

    task automatic test_r_type();
        logic [2:0]  f3s [10] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                                  3'b001, 3'b101, 3'b101, 3'b010, 3'b011};
        logic        alts [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        logic [31:0] a;
        logic [31:0] b;
        int          e0;
        e0 = errors;
        a = next_random() | 32'h8000_0000;  // negative, so slt and sltu disagree
        b = next_random() & 32'h7fff_ffff;
        hold_reset();
        clear_memories();
        dmem[0] = a;
        dmem[1] = b;
        put(i_word(riscv_isa_pkg::op_load, 3'b010, 5'd1, 5'd0, 12'd0));
        put(i_word(riscv_isa_pkg::op_load, 3'b010, 5'd2, 5'd0, 12'd4));
        for (int k = 0; k < 10; k++) begin
            put(r_word(f3s[k], alts[k], 5'd3, 5'd1, 5'd2));
            put(s_word(5'd3, 5'd0, 12'h040 + 12'(4 * k)));
        end
        put(s_word(5'd0, 5'd0, done_addr[11:0]));
        run_program();
        for (int k = 0; k < 10; k++) begin
            compare($sformatf("dmem[%0d]", 16 + k), dmem[16 + k],
                    model_alu(f3s[k], alts[k], a, b));
        end
        report("r_type", e0);
    endtask

    task automatic test_imm_mem();
        logic [2:0]  f3s [9] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110,
                                 3'b111, 3'b001, 3'b101, 3'b101};
        logic        alts [9] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        logic [11:0] imms [9];
        logic [31:0] a;
        logic [31:0] r;
        int          e0;
        e0 = errors;
        a = next_random();
        for (int k = 0; k < 9; k++) begin
            r = next_random();
            if (f3s[k] == 3'b001 || f3s[k] == 3'b101) begin
                imms[k] = {1'b0, alts[k], 5'd0, r[4:0]};  // shamt, bit 10 for srai
            end else begin
                imms[k] = {1'b1, r[10:0]};
            end
        end
        hold_reset();
        clear_memories();
        dmem[0] = a;
        put(i_word(riscv_isa_pkg::op_load, 3'b010, 5'd1, 5'd0, 12'd0));
        put(i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd5, 5'd0, 12'h080));  // store base
        for (int k = 0; k < 9; k++) begin
            put(i_word(riscv_isa_pkg::op_imm, f3s[k], 5'd3, 5'd1, imms[k]));
            put(s_word(5'd3, 5'd5, 12'(-4 * (k + 1))));
        end
        put(i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd0, 5'd1, 12'h123));  // x0 stays zero
        put(s_word(5'd0, 5'd0, 12'h090));
        put(s_word(5'd0, 5'd0, done_addr[11:0]));
        run_program();
        for (int k = 0; k < 9; k++) begin
            compare($sformatf("dmem[%0d]", 31 - k), dmem[31 - k],
                    model_alu(f3s[k], alts[k], a, {{20{imms[k][11]}}, imms[k]}));
        end
        compare("x0", dmem[36], 32'd0);
        report("imm_mem", e0);
    endtask

    task automatic test_branches();
        logic [2:0]  f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [31:0] ops [6];
        logic [31:0] x;
        int          slot;
        int          e0;
        e0 = errors;
        x = next_random();
        ops[0] = x;  // equal pair
        ops[1] = x;
        ops[2] = next_random() | 32'h8000_0000;  // signed less, unsigned greater
        ops[3] = next_random() & 32'h7fff_ffff;
        ops[4] = ops[3];
        ops[5] = ops[2];
        hold_reset();
        clear_memories();
        for (int k = 0; k < 6; k++) begin
            dmem[k] = ops[k];
        end
        put(i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd7, 5'd0, 12'd1));  // skipped marker
        put(i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd8, 5'd0, 12'd2));  // taken marker
        for (int p = 0; p < 3; p++) begin
            put(i_word(riscv_isa_pkg::op_load, 3'b010, 5'd1, 5'd0, 12'(8 * p)));
            put(i_word(riscv_isa_pkg::op_load, 3'b010, 5'd2, 5'd0, 12'(8 * p + 4)));
            for (int f = 0; f < 6; f++) begin
                slot = 64 + 6 * p + f;
                put(b_word(f3s[f], 5'd1, 5'd2, 13'd12));
                put(s_word(5'd7, 5'd0, 12'(slot * 4)));
                put(j_word(5'd0, 21'd8));
                put(s_word(5'd8, 5'd0, 12'(slot * 4)));
            end
        end
        put(s_word(5'd0, 5'd0, done_addr[11:0]));
        run_program();
        for (int p = 0; p < 3; p++) begin
            for (int f = 0; f < 6; f++) begin
                compare($sformatf("dmem[%0d]", 64 + 6 * p + f), dmem[64 + 6 * p + f],
                        model_taken(f3s[f], ops[2 * p], ops[2 * p + 1]) ? 32'd2 : 32'd1);
            end
        end
        report("branches", e0);
    endtask

    task automatic test_jumps();
        int e0;
        e0 = errors;
        hold_reset();
        clear_memories();
        put(j_word(5'd1, 21'd16));
        wr_idx = wr_idx + 3;  // jumped over
        put(s_word(5'd1, 5'd0, 12'h200));
        put(i_word(riscv_isa_pkg::op_imm, 3'b000, 5'd2, 5'd0, reset_addr[11:0] + 12'h021));
        put(i_word(riscv_isa_pkg::op_jalr, 3'b000, 5'd3, 5'd2, 12'd4));  // odd sum
        wr_idx = wr_idx + 2;
        put(s_word(5'd3, 5'd0, 12'h204));
        put(s_word(5'd0, 5'd0, done_addr[11:0]));
        run_program();
        compare("dmem[128]", dmem[128], reset_addr + 32'd4);
        compare("dmem[129]", dmem[129], reset_addr + 32'd28);
        compare("imem_addr", trace[1], reset_addr + 32'd16);
        compare("imem_addr", trace[4], reset_addr + 32'd36);
        report("jumps", e0);
    endtask

    initial begin
        reset     = 1'b1;
        errors    = 0;
        tests     = 0;
        lcg_state = 32'd29;
        clear_memories();
        test_reset();
        test_r_type();
        test_imm_mem();
        test_branches();
        test_jumps();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]                a,
    input  logic [31:0]                b,
    input  riscv_ctrl_pkg::alu_op_t    op,
    output logic [31:0]                result,
    output riscv_ctrl_pkg::alu_flags_t flags
);
    logic        sub_mode;
    logic [31:0] b_eff;
    logic [32:0] sum;
    logic        ovf;
    logic [4:0]  shamt;

    // one adder serves add, sub and both compares
    assign sub_mode = (op == riscv_ctrl_pkg::alu_op_sub) ||
                      (op == riscv_ctrl_pkg::alu_op_slt) ||
                      (op == riscv_ctrl_pkg::alu_op_sltu);
    assign b_eff    = sub_mode ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {32'd0, sub_mode};

    // operands agree in sign but the sum does not
    assign ovf = (a[31] == b_eff[31]) && (sum[31] != a[31]);

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            riscv_ctrl_pkg::alu_op_add,
            riscv_ctrl_pkg::alu_op_sub:  result = sum[31:0];
            riscv_ctrl_pkg::alu_op_and:  result = a & b;
            riscv_ctrl_pkg::alu_op_or:   result = a | b;
            riscv_ctrl_pkg::alu_op_xor:  result = a ^ b;
            riscv_ctrl_pkg::alu_op_sll:  result = a << shamt;
            riscv_ctrl_pkg::alu_op_srl:  result = a >> shamt;
            riscv_ctrl_pkg::alu_op_sra:  result = $unsigned($signed(a) >>> shamt);
            riscv_ctrl_pkg::alu_op_slt:  result = {31'd0, sum[31] ^ ovf};
            riscv_ctrl_pkg::alu_op_sltu: result = {31'd0, ~sum[32]};  // borrow out
            default:                     result = sum[31:0];
        endcase
    end

    assign flags.neg  = result[31];
    assign flags.zero = (result == 32'd0);
    assign flags.cout = sum[32];
    assign flags.ovf  = ovf;
endmodule

// File: verilog/controller.sv
`timescale 1ns/1ps

// picks the ALU operation from opcode and function fields
module alu_dec (
    input  riscv_isa_pkg::opcode_t  op,
    input  logic [2:0]              func3,
    input  logic [6:0]              func7,
    output riscv_ctrl_pkg::alu_op_t alu_ctrl
);
    logic                    alt;
    riscv_ctrl_pkg::alu_op_t arith_op;

    // I-type only honours func7 on right shifts
    assign alt = func7[riscv_isa_pkg::f7_alt_bit] &
                 ((op == riscv_isa_pkg::op_reg) || (func3 == riscv_isa_pkg::f3_srl_sra));

    always_comb begin
        case (func3)
            riscv_isa_pkg::f3_add_sub: arith_op = alt ? riscv_ctrl_pkg::alu_op_sub
                                                      : riscv_ctrl_pkg::alu_op_add;
            riscv_isa_pkg::f3_sll:     arith_op = riscv_ctrl_pkg::alu_op_sll;
            riscv_isa_pkg::f3_slt:     arith_op = riscv_ctrl_pkg::alu_op_slt;
            riscv_isa_pkg::f3_sltu:    arith_op = riscv_ctrl_pkg::alu_op_sltu;
            riscv_isa_pkg::f3_xor:     arith_op = riscv_ctrl_pkg::alu_op_xor;
            riscv_isa_pkg::f3_srl_sra: arith_op = alt ? riscv_ctrl_pkg::alu_op_sra
                                                      : riscv_ctrl_pkg::alu_op_srl;
            riscv_isa_pkg::f3_or:      arith_op = riscv_ctrl_pkg::alu_op_or;
            default:                   arith_op = riscv_ctrl_pkg::alu_op_and;
        endcase
    end

    always_comb begin
        case (op)
            riscv_isa_pkg::op_reg,
            riscv_isa_pkg::op_imm:    alu_ctrl = arith_op;
            riscv_isa_pkg::op_branch: alu_ctrl = riscv_ctrl_pkg::alu_op_sub;  // compare
            default:                  alu_ctrl = riscv_ctrl_pkg::alu_op_add;  // addresses
        endcase
    end
endmodule

// main decoder and branch resolution
module controller (
    input  logic                       reset,
    input  riscv_isa_pkg::instr_t      instr,
    input  riscv_ctrl_pkg::alu_flags_t alu_flags,
    ctrl_if.ctrl                       ctrl
);
    logic                     reg_we_dec;
    logic                     mem_we_dec;
    riscv_ctrl_pkg::alu_src_t alu_src;
    riscv_ctrl_pkg::res_src_t result_src;
    riscv_ctrl_pkg::pc_src_t  pc_src;
    riscv_ctrl_pkg::imm_src_t imm_src;
    riscv_ctrl_pkg::pc_src_t  pc_src_branch;
    logic                     taken;
    logic                     lt_signed;
    logic                     lt_unsigned;

    alu_dec alu_dec_inst (
        .op       (instr.r.opcode),
        .func3    (instr.r.func3),
        .func7    (instr.r.func7),
        .alu_ctrl (ctrl.alu_ctrl)
    );

    // flags come from rs1 - rs2
    assign lt_signed   = alu_flags.neg ^ alu_flags.ovf;
    assign lt_unsigned = ~alu_flags.cout;  // borrow

    always_comb begin
        case (instr.b.func3)
            riscv_isa_pkg::f3_beq:  taken = alu_flags.zero;
            riscv_isa_pkg::f3_bne:  taken = ~alu_flags.zero;
            riscv_isa_pkg::f3_blt:  taken = lt_signed;
            riscv_isa_pkg::f3_bge:  taken = ~lt_signed;
            riscv_isa_pkg::f3_bltu: taken = lt_unsigned;
            riscv_isa_pkg::f3_bgeu: taken = ~lt_unsigned;
            default:                taken = 1'b0;
        endcase
    end

    assign pc_src_branch = taken ? riscv_ctrl_pkg::pc_src_plus_off
                                 : riscv_ctrl_pkg::pc_src_plus_4;

    always_comb begin
        // unknown opcode falls through as a no-op
        reg_we_dec = 1'b0;
        mem_we_dec = 1'b0;
        alu_src    = riscv_ctrl_pkg::alu_src_reg;
        result_src = riscv_ctrl_pkg::res_src_alu_out;
        pc_src     = riscv_ctrl_pkg::pc_src_plus_4;
        imm_src    = riscv_ctrl_pkg::imm_src_itype;
        case (instr.r.opcode)
            riscv_isa_pkg::op_load: begin
                reg_we_dec = 1'b1;
                alu_src    = riscv_ctrl_pkg::alu_src_ext_imm;
                result_src = riscv_ctrl_pkg::res_src_read_data;
            end
            riscv_isa_pkg::op_imm: begin
                reg_we_dec = 1'b1;
                alu_src    = riscv_ctrl_pkg::alu_src_ext_imm;
            end
            riscv_isa_pkg::op_store: begin
                mem_we_dec = 1'b1;
                alu_src    = riscv_ctrl_pkg::alu_src_ext_imm;
                imm_src    = riscv_ctrl_pkg::imm_src_stype;
            end
            riscv_isa_pkg::op_reg: reg_we_dec = 1'b1;
            riscv_isa_pkg::op_branch: begin
                pc_src  = pc_src_branch;
                imm_src = riscv_ctrl_pkg::imm_src_btype;
            end
            riscv_isa_pkg::op_jal: begin
                reg_we_dec = 1'b1;
                result_src = riscv_ctrl_pkg::res_src_pc_plus_4;
                pc_src     = riscv_ctrl_pkg::pc_src_plus_off;
                imm_src    = riscv_ctrl_pkg::imm_src_jtype;
            end
            riscv_isa_pkg::op_jalr: begin
                reg_we_dec = 1'b1;
                alu_src    = riscv_ctrl_pkg::alu_src_ext_imm;  // target via ALU
                result_src = riscv_ctrl_pkg::res_src_pc_plus_4;
                pc_src     = riscv_ctrl_pkg::pc_src_reg_plus_off;
            end
            default: ;
        endcase
    end

    // no state changes while reset is held
    assign ctrl.reg_we     = reg_we_dec & ~reset;
    assign ctrl.mem_we     = mem_we_dec & ~reset;
    assign ctrl.alu_src    = alu_src;
    assign ctrl.result_src = result_src;
    assign ctrl.pc_src     = pc_src;
    assign ctrl.imm_src    = imm_src;
endmodule

// File: verilog/ctrl_if.sv
`timescale 1ns/1ps

// control bundle, controller to datapath
interface ctrl_if;
    logic                    reg_we;
    logic                    mem_we;
    riscv_ctrl_pkg::alu_src_t alu_src;
    riscv_ctrl_pkg::res_src_t result_src;
    riscv_ctrl_pkg::pc_src_t  pc_src;
    riscv_ctrl_pkg::imm_src_t imm_src;
    riscv_ctrl_pkg::alu_op_t  alu_ctrl;

    modport ctrl (
        output reg_we, mem_we, alu_src, result_src, pc_src, imm_src, alu_ctrl
    );

    modport dp (
        input reg_we, mem_we, alu_src, result_src, pc_src, imm_src, alu_ctrl
    );
endinterface

// File: verilog/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter logic [31:0] reset_addr = 32'h0
) (
    input  logic                       clk,
    input  logic                       reset,
    ctrl_if.dp                         ctrl,
    output riscv_isa_pkg::instr_t      instr,
    output riscv_ctrl_pkg::alu_flags_t alu_flags,
    output logic [31:0]                imem_addr,
    input  logic [31:0]                imem_data,
    output logic [31:0]                dmem_addr,
    output logic [31:0]                dmem_wdata,
    input  logic [31:0]                dmem_rdata
);
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_plus_off;
    logic [31:0] regs [1:31];  // x0 is not stored
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_ext;
    logic [31:0] src_b;
    logic [31:0] alu_result;
    logic [31:0] result;

    assign instr     = imem_data;
    assign imem_addr = pc;

    // register reads, x0 hardwired to zero
    assign rs1_val = (instr.r.rs1 == 5'd0) ? 32'd0 : regs[instr.r.rs1];
    assign rs2_val = (instr.r.rs2 == 5'd0) ? 32'd0 : regs[instr.r.rs2];

    // sign-extended immediate, reassembled per format
    always_comb begin
        case (ctrl.imm_src)
            riscv_ctrl_pkg::imm_src_stype:
                imm_ext = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            riscv_ctrl_pkg::imm_src_btype:
                imm_ext = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                           instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            riscv_ctrl_pkg::imm_src_jtype:
                imm_ext = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                           instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default:
                imm_ext = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        endcase
    end

    assign src_b = (ctrl.alu_src == riscv_ctrl_pkg::alu_src_ext_imm) ? imm_ext : rs2_val;

    alu alu_inst (
        .a      (rs1_val),
        .b      (src_b),
        .op     (ctrl.alu_ctrl),
        .result (alu_result),
        .flags  (alu_flags)
    );

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_val;

    assign pc_plus_4   = pc + 32'd4;
    assign pc_plus_off = pc + imm_ext;

    always_comb begin
        case (ctrl.result_src)
            riscv_ctrl_pkg::res_src_read_data: result = dmem_rdata;
            riscv_ctrl_pkg::res_src_pc_plus_4: result = pc_plus_4;  // link
            default:                           result = alu_result;
        endcase
    end

    always_comb begin
        case (ctrl.pc_src)
            riscv_ctrl_pkg::pc_src_plus_off:     pc_next = pc_plus_off;
            riscv_ctrl_pkg::pc_src_reg_plus_off: pc_next = {alu_result[31:1], 1'b0};
            default:                             pc_next = pc_plus_4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_addr;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= 32'd0;
            end
        end else if (ctrl.reg_we && (instr.r.rd != 5'd0)) begin
            regs[instr.r.rd] <= result;  // writes to x0 dropped
        end
    end
endmodule

// File: verilog/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter logic [31:0] reset_addr = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_we,
    input  logic [31:0] dmem_rdata
);
    riscv_isa_pkg::instr_t      instr;
    riscv_ctrl_pkg::alu_flags_t alu_flags;

    ctrl_if ctrl_bus ();

    controller controller_inst (
        .reset     (reset),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl_bus.ctrl)
    );

    datapath #(
        .reset_addr (reset_addr)
    ) datapath_inst (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl_bus.dp),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    assign dmem_we = ctrl_bus.mem_we;  // already held low in reset
endmodule

// File: verilog/riscv_ctrl_pkg.sv
package riscv_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_op_add  = 4'd0,
        alu_op_sub  = 4'd1,
        alu_op_and  = 4'd2,
        alu_op_or   = 4'd3,
        alu_op_xor  = 4'd4,
        alu_op_sll  = 4'd5,
        alu_op_srl  = 4'd6,
        alu_op_sra  = 4'd7,
        alu_op_slt  = 4'd8,
        alu_op_sltu = 4'd9
    } alu_op_t;

    // second ALU operand
    typedef enum logic [1:0] {
        alu_src_reg     = 2'd0,
        alu_src_ext_imm = 2'd1
    } alu_src_t;

    // register write-back value
    typedef enum logic [1:0] {
        res_src_alu_out   = 2'd0,
        res_src_read_data = 2'd1,
        res_src_pc_plus_4 = 2'd2
    } res_src_t;

    typedef enum logic [1:0] {
        pc_src_plus_4       = 2'd0,
        pc_src_plus_off     = 2'd1,
        pc_src_reg_plus_off = 2'd2   // jalr
    } pc_src_t;

    // immediate layout within the word
    typedef enum logic [2:0] {
        imm_src_itype = 3'd0,
        imm_src_stype = 3'd1,
        imm_src_btype = 3'd2,
        imm_src_jtype = 3'd3
    } imm_src_t;

    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;
        logic ovf;
    } alu_flags_t;

endpackage

// File: verilog/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_t;

    // func3 for register and immediate arithmetic
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // func3 for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam int f7_alt_bit = 5;  // picks sub / sra

    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_format_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_format_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_format_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_format_t;

    // one instruction word, seen through each encoding
    typedef union packed {
        r_format_t r;
        i_format_t i;
        s_format_t s;
        b_format_t b;
        j_format_t j;
    } instr_t;

endpackage
